//--- logic/bru_pkg.sv
// shared widths, rv32i opcode constants and payload structs; import into any branch-unit module
package bru_pkg;

    // pc and target width
    localparam int INST_ADDR_WIDTH = 32;

    // rv32i major opcodes the decoder knows
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111; // fence, fence.i

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // one-hot control-flow class, req marks any of them
    typedef struct packed {
        logic jal;
        logic jalr;
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic fence;
        logic req;   // item is control flow at all
    } bjp_op_t;

    // item as handed over by the issuer
    typedef struct packed {
        logic [31:0]                instr;
        logic [INST_ADDR_WIDTH-1:0] pc;
        logic [31:0]                rs1_val;
        logic [31:0]                rs2_val;
        logic                       pred_taken; // fetch already went to the target
        logic                       int_assert;
        logic [INST_ADDR_WIDTH-1:0] int_addr;   // interrupt vector
    } issue_t;

    // decoder to resolver
    typedef struct packed {
        bjp_op_t                    op;
        logic [31:0]                op1;      // compare operands
        logic [31:0]                op2;
        logic [INST_ADDR_WIDTH-1:0] jump_op1; // adder base
        logic [INST_ADDR_WIDTH-1:0] jump_op2; // adder offset
        logic                       is_pred;  // predicted conditional branch
        logic                       int_assert;
        logic [INST_ADDR_WIDTH-1:0] int_addr;
        logic [INST_ADDR_WIDTH-1:0] pc;       // carried for the echo
    } bjp_req_t;

    // resolution record sent to fetch
    typedef struct packed {
        logic                       jump;
        logic                       misaligned;
        logic [INST_ADDR_WIDTH-1:0] addr;
        logic [INST_ADDR_WIDTH-1:0] pc;    // lets fetch match the record
    } redirect_t;

endpackage

//--- logic/hs_slot.sv
// one-entry holding slot with four-phase req/ack on the load side; set payload_t per use
`timescale 1ns/1ps

module hs_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_i,
    // load side, four-phase
    input  logic     load_req_i,
    input  payload_t load_data_i,
    output logic     load_ack_o,
    // held entry
    output logic     full_o,
    output payload_t data_o,
    input  logic     release_i,  // issue role, rising edge frees the entry
    // hold side, redirect role
    output logic     hold_req_o,
    input  logic     hold_ack_i
);
    logic     req_q;   // sampled load req
    logic     ack_q;
    logic     full_q;
    logic     wait_q;  // hold ack seen, waiting for it to drop
    logic     rel_q;
    logic     accept;
    logic     rel_rise;
    logic     drain;
    payload_t data_q;

    // take a new item only when idle on both sides
    assign accept   = req_q & ~full_q & ~ack_q & ~wait_q;
    assign rel_rise = release_i & ~rel_q;            // one pulse per load downstream
    assign drain    = full_q & (rel_rise | hold_ack_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_q  <= 1'b0;
            ack_q  <= 1'b0;
            full_q <= 1'b0;
            wait_q <= 1'b0;
            rel_q  <= 1'b0;
        end else begin
            req_q <= load_req_i;
            rel_q <= release_i;
            if (accept) begin
                ack_q <= 1'b1;                       // captured
            end else if (!req_q) begin
                ack_q <= 1'b0;                       // requester let go
            end
            if (accept) begin
                full_q <= 1'b1;
            end else if (drain) begin
                full_q <= 1'b0;
            end
            if (full_q && hold_ack_i) begin
                wait_q <= 1'b1;
            end else if (!hold_ack_i) begin
                wait_q <= 1'b0;                      // back to idle once ack is low
            end
        end
    end

    // payload only, control bits above carry the validity
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= load_data_i;
        end
    end

    assign load_ack_o = ack_q;
    assign full_o     = full_q;
    assign data_o     = data_q;
    assign hold_req_o = full_q;   // falls on the edge that sees ack

endmodule

//--- logic/bjp_decode.sv
// decodes one issue item into control-flow flags and adder operands; purely combinational
`timescale 1ns/1ps

module bjp_decode import bru_pkg::*; (
    input  issue_t   issue_i,
    output bjp_req_t bjp_o
);
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [31:0]                imm_b;
    logic [31:0]                imm_j;
    logic [31:0]                imm_i;
    logic                       is_branch;
    bjp_op_t                    op;
    logic [INST_ADDR_WIDTH-1:0] jump_op1;
    logic [INST_ADDR_WIDTH-1:0] jump_op2;

    assign opcode = issue_i.instr[6:0];
    assign funct3 = issue_i.instr[14:12];

    // b-type, 13 bit signed offset
    assign imm_b = {{20{issue_i.instr[31]}}, issue_i.instr[7],
                    issue_i.instr[30:25], issue_i.instr[11:8], 1'b0};
    // j-type, 21 bit signed offset
    assign imm_j = {{12{issue_i.instr[31]}}, issue_i.instr[19:12],
                    issue_i.instr[20], issue_i.instr[30:21], 1'b0};
    // i-type for jalr
    assign imm_i = {{20{issue_i.instr[31]}}, issue_i.instr[31:20]};

    always_comb begin
        op = '0;
        if (opcode == OPC_BRANCH) begin
            case (funct3)
                F3_BEQ:  op.beq  = 1'b1;
                F3_BNE:  op.bne  = 1'b1;
                F3_BLT:  op.blt  = 1'b1;
                F3_BGE:  op.bge  = 1'b1;
                F3_BLTU: op.bltu = 1'b1;
                F3_BGEU: op.bgeu = 1'b1;
                default: ;                         // 010/011 reserved, not control flow
            endcase
        end
        op.jal   = (opcode == OPC_JAL);
        op.jalr  = (opcode == OPC_JALR);
        op.fence = (opcode == OPC_MISC_MEM);      // fence and fence.i alike
        op.req   = op.jal | op.jalr | op.beq | op.bne | op.blt | op.bge
                 | op.bltu | op.bgeu | op.fence;
    end

    assign is_branch = op.beq | op.bne | op.blt | op.bge | op.bltu | op.bgeu;

    // adder operands per class
    always_comb begin
        jump_op1 = issue_i.pc;
        jump_op2 = INST_ADDR_WIDTH'(4);            // fence refetches pc+4
        if (is_branch) begin
            jump_op2 = imm_b;
        end else if (op.jal) begin
            jump_op2 = imm_j;
        end else if (op.jalr) begin
            jump_op1 = issue_i.rs1_val;            // register base
            jump_op2 = imm_i;
        end
    end

    assign bjp_o = '{
        op:         op,
        op1:        issue_i.rs1_val,
        op2:        issue_i.rs2_val,
        jump_op1:   jump_op1,
        jump_op2:   jump_op2,
        is_pred:    issue_i.pred_taken & is_branch, // prediction only on cond branches
        int_assert: issue_i.int_assert,
        int_addr:   issue_i.int_addr,
        pc:         issue_i.pc
    };

endmodule

//--- logic/exu_bru.sv
// branch resolution: condition, target, rollback, interrupt override and misalignment
`timescale 1ns/1ps

module exu_bru import bru_pkg::*; (
    input  bjp_req_t  bjp_i,
    output redirect_t redirect_o
);
    logic                       op1_eq_op2;
    logic                       op1_ge_s;
    logic                       op1_ge_u;
    logic                       branch_cond;
    logic                       rollback;
    logic                       jump_raw;
    logic                       misaligned;
    logic [INST_ADDR_WIDTH-1:0] adder_op2;
    logic [INST_ADDR_WIDTH-1:0] adder_sum;
    logic [INST_ADDR_WIDTH-1:0] target;
    logic [INST_ADDR_WIDTH-1:0] jump_addr;

    // compares
    assign op1_eq_op2 = (bjp_i.op1 == bjp_i.op2);
    assign op1_ge_s   = $signed(bjp_i.op1) >= $signed(bjp_i.op2);
    assign op1_ge_u   = (bjp_i.op1 >= bjp_i.op2);

    // selected compare, jalr always taken
    assign branch_cond = bjp_i.op.req & (
        (bjp_i.op.beq  &  op1_eq_op2) |
        (bjp_i.op.bne  & ~op1_eq_op2) |
        (bjp_i.op.blt  & ~op1_ge_s)   |
        (bjp_i.op.bge  &  op1_ge_s)   |
        (bjp_i.op.bltu & ~op1_ge_u)   |
        (bjp_i.op.bgeu &  op1_ge_u)   |
        bjp_i.op.jalr
    );

    // fetch went to the target but the branch falls through
    assign rollback = bjp_i.is_pred & bjp_i.op.req & ~branch_cond;

    // same adder, +4 when rolling back
    assign adder_op2 = rollback ? INST_ADDR_WIDTH'(4) : bjp_i.jump_op2;
    assign adder_sum = bjp_i.jump_op1 + adder_op2;

    // jalr drops bit 0
    assign target = bjp_i.op.jalr ? {adder_sum[INST_ADDR_WIDTH-1:1], 1'b0} : adder_sum;

    assign jump_addr = bjp_i.int_assert ? bjp_i.int_addr : target; // interrupt wins

    // predicted taken branches are already on the right path
    assign jump_raw = bjp_i.int_assert
                    | (branch_cond & ~bjp_i.is_pred)
                    | bjp_i.op.fence
                    | rollback;

    // jal counts even though fetch handles its redirect
    assign misaligned = (jump_addr[1:0] != 2'b00) & (jump_raw | bjp_i.op.jal);

    assign redirect_o = '{
        jump:       jump_raw & ~misaligned,   // no redirect to a bad address
        misaligned: misaligned,
        addr:       jump_addr,
        pc:         bjp_i.pc
    };

endmodule

//--- logic/bru_top.sv
// branch resolution slice top: issue slot, decode, resolver and redirect slot in a chain
`timescale 1ns/1ps

module bru_top import bru_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    // issuer, four-phase
    input  logic      issue_req_i,
    input  issue_t    issue_i,
    output logic      issue_ack_o,
    // fetch, four-phase
    output logic      redirect_req_o,
    output redirect_t redirect_o,
    input  logic      redirect_ack_i
);
    logic      issue_full;    // issue slot holds an item
    issue_t    issue_item;
    bjp_req_t  bjp_req;
    redirect_t redirect_next;
    logic      redirect_taken; // redirect slot load ack, frees the issue slot

    hs_slot #(.payload_t(issue_t)) issue_slot_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .load_req_i  (issue_req_i),
        .load_data_i (issue_i),
        .load_ack_o  (issue_ack_o),
        .full_o      (issue_full),
        .data_o      (issue_item),
        .release_i   (redirect_taken),
        .hold_req_o  (),              // not used in this role
        .hold_ack_i  (1'b0)
    );

    bjp_decode bjp_decode_inst (
        .issue_i (issue_item),
        .bjp_o   (bjp_req)
    );

    exu_bru exu_bru_inst (
        .bjp_i      (bjp_req),
        .redirect_o (redirect_next)
    );

    // full flag of the issue slot acts as its load request
    hs_slot #(.payload_t(redirect_t)) redirect_slot_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .load_req_i  (issue_full),
        .load_data_i (redirect_next),
        .load_ack_o  (redirect_taken),
        .full_o      (),              // same as hold req
        .data_o      (redirect_o),
        .release_i   (1'b0),          // emptied by fetch ack instead
        .hold_req_o  (redirect_req_o),
        .hold_ack_i  (redirect_ack_i)
    );

endmodule

//--- dv/bru_properties.sv
// four-phase handshake checks on both sides of bru_top, attached to it by the bind below
`timescale 1ns/1ps

module bru_properties import bru_pkg::*; (
    input logic      clk,
    input logic      rst_i,
    input logic      issue_req_i,
    input logic      issue_ack_o,
    input logic      redirect_req_o,
    input logic      redirect_ack_i,
    input redirect_t redirect_o
);
    // issuer may only let go of req once ack is up
    issue_req_hold: assert property (@(posedge clk) disable iff (rst_i)
        $fell(issue_req_i) |-> issue_ack_o)
        else $error("issue req dropped before ack");

    // fetch ack drops right after req falls, so look one edge back
    redirect_req_hold: assert property (@(posedge clk) disable iff (rst_i)
        $fell(redirect_req_o) |-> $past(redirect_ack_i))
        else $error("redirect req dropped before ack");

    issue_ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(issue_ack_o) |-> $past(issue_req_i))
        else $error("issue ack rose without req");

    redirect_ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(redirect_ack_i) |-> redirect_req_o)
        else $error("redirect ack rose without req");

    // record frozen for the whole request phase
    redirect_data_stable: assert property (@(posedge clk) disable iff (rst_i)
        redirect_req_o && $past(redirect_req_o) |-> $stable(redirect_o))
        else $error("redirect record changed while req high");

endmodule

bind bru_top bru_properties bru_properties_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .issue_req_i    (issue_req_i),
    .issue_ack_o    (issue_ack_o),
    .redirect_req_o (redirect_req_o),
    .redirect_ack_i (redirect_ack_i),
    .redirect_o     (redirect_o)
);

//--- dv/tb_bru_top.sv
// testbench for bru_top: directed and lcg-random control-flow items checked against a model
`timescale 1ns/1ps

module tb_bru_top import bru_pkg::*; ();
    localparam int          CLK_PERIOD = 20;
    localparam int          N_RANDOM   = 400;
    localparam int          N_ITEMS    = N_RANDOM + 9;   // random, directed, latency
    localparam logic [31:0] SEED       = 32'h20fd6afa;
    localparam logic [17:0] BR_F3      = {3'b111, 3'b110, 3'b101, 3'b100, 3'b001, 3'b000};

    logic        clk;
    logic        rst;
    logic        issue_req;
    issue_t      issue_item;
    logic        issue_ack;
    logic        redir_req;
    redirect_t   redir_rec;
    logic        redir_ack;
    redirect_t   exp_q[$];      // expected records, issue order
    logic [31:0] stim_state;
    logic [31:0] fetch_state;   // separate stream for ack delays
    string       test_name;
    int          errors;
    int          items;
    int          records;
    int          n_tests;
    int          err_start;
    int          item_start;

    bru_top bru_top_inst (
        .clk            (clk),
        .rst_i          (rst),
        .issue_req_i    (issue_req),
        .issue_i        (issue_item),
        .issue_ack_o    (issue_ack),
        .redirect_req_o (redir_req),
        .redirect_o     (redir_rec),
        .redirect_ack_i (redir_ack)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] draw16();
        stim_state = lcg_step(stim_state);
        return stim_state[31:16];   // upper half, low bits are weak
    endfunction

    // classes: 0..5 branches, 6 jal, 7 jalr, 8 fence, 9 alu op
    function automatic issue_t make_item(input int cls, input logic [31:0] imm,
                                         input logic [31:0] bits, input logic [31:0] pc,
                                         input logic [31:0] rs1, input logic [31:0] rs2,
                                         input logic pred, input logic intr,
                                         input logic [31:0] iaddr);
        issue_t it;
        if (cls < 6) begin
            it.instr = {imm[12], imm[10:5], bits[24:15], BR_F3[5'(cls * 3) +: 3],
                        imm[4:1], imm[11], OPC_BRANCH};
        end else if (cls == 6) begin
            it.instr = {imm[20], imm[10:1], imm[11], imm[19:12], bits[11:7], OPC_JAL};
        end else if (cls == 7) begin
            it.instr = {imm[11:0], bits[19:15], 3'b000, bits[11:7], OPC_JALR};
        end else if (cls == 8) begin
            it.instr = {bits[31:15], 3'b000, bits[11:7], OPC_MISC_MEM};
        end else begin
            it.instr = {bits[31:7], 7'b0110011};   // register alu op
        end
        it.pc         = pc;
        it.rs1_val    = rs1;
        it.rs2_val    = rs2;
        it.pred_taken = pred;
        it.int_assert = intr;
        it.int_addr   = iaddr;
        return it;
    endfunction

    function automatic issue_t random_item();
        int          cls;
        logic [31:0] imm;
        logic [31:0] bits;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [15:0] ctl;
        cls  = int'(draw16() % 16'd10);
        imm  = {draw16(), draw16()};
        bits = {draw16(), draw16()};
        rs1  = {draw16(), draw16()};
        rs2  = {draw16(), draw16()};
        ctl  = draw16();
        if (ctl[1:0] != 2'b00) begin
            imm[1] = 1'b0;   // misaligned offsets 1 in 4
            rs1[1] = 1'b0;
        end
        if (ctl[3:2] == 2'b00) begin
            rs2 = rs1;       // equal operands for beq/bne
        end
        return make_item(cls, imm, bits, {draw16(), draw16()} & ~32'h3, rs1, rs2,
                         ctl[7:6] == 2'b00, ctl[11:8] == 4'h0, {draw16(), draw16()} & ~32'h3);
    endfunction

    // expected record straight from the rv32i rules
    function automatic redirect_t model(input issue_t it);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        br;
        logic        taken;
        logic        pred;
        logic        jal;
        logic        jalr;
        logic        raw;
        logic [31:0] off;
        logic [31:0] tgt;
        redirect_t   r;
        opc = it.instr[6:0];
        f3  = it.instr[14:12];
        br  = (opc == OPC_BRANCH) && (f3 != 3'b010) && (f3 != 3'b011);
        case (f3)
            3'b000:  taken = it.rs1_val == it.rs2_val;
            3'b001:  taken = it.rs1_val != it.rs2_val;
            3'b100:  taken = $signed(it.rs1_val) < $signed(it.rs2_val);
            3'b101:  taken = $signed(it.rs1_val) >= $signed(it.rs2_val);
            3'b110:  taken = it.rs1_val < it.rs2_val;
            default: taken = it.rs1_val >= it.rs2_val;
        endcase
        jal  = opc == OPC_JAL;
        jalr = opc == OPC_JALR;
        pred = it.pred_taken && br;   // only branches carry a prediction
        if (br && pred && !taken) begin
            off = 32'd4;              // rollback to fall-through
        end else if (br) begin
            off = {{19{it.instr[31]}}, it.instr[31], it.instr[7], it.instr[30:25],
                   it.instr[11:8], 1'b0};
        end else if (jal) begin
            off = {{11{it.instr[31]}}, it.instr[31], it.instr[19:12], it.instr[20],
                   it.instr[30:21], 1'b0};
        end else if (jalr) begin
            off = {{20{it.instr[31]}}, it.instr[31:20]};
        end else begin
            off = 32'd4;              // fence and non-control refetch pc+4
        end
        tgt = (jalr ? it.rs1_val : it.pc) + off;
        if (jalr) begin
            tgt[0] = 1'b0;
        end
        r.pc         = it.pc;
        r.addr       = it.int_assert ? it.int_addr : tgt;
        raw          = it.int_assert || (br && taken != pred) || jalr
                       || (opc == OPC_MISC_MEM);
        r.misaligned = (r.addr[1:0] != 2'b00) && (raw || jal);
        r.jump       = raw && !r.misaligned;
        return r;
    endfunction

    // one full four-phase transfer on the issue side
    task automatic send_item(input issue_t it);
        @(negedge clk);
        issue_item = it;
        exp_q.push_back(model(it));
        items++;
        issue_req = 1'b1;
        do @(negedge clk); while (!issue_ack);
        issue_req = 1'b0;
        do @(negedge clk); while (issue_ack);
    endtask

    task automatic measure_latency();
        int n;
        n = 0;
        @(negedge clk);   // same edge the request is driven on
        @(posedge clk);   // edge that samples it
        @(negedge clk);
        while (!redir_req && n < 10) begin
            n++;
            @(negedge clk);
        end
        assert (n == 3) else begin
            $display("Mismatch in %s: expected %0d cycles actual %0d", test_name, 3, n);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        err_start  = errors;
        item_start = items;
    endtask

    task automatic end_test();
        while (exp_q.size() != 0 || redir_req || redir_ack) begin
            @(negedge clk);   // drain outstanding records
        end
        n_tests++;
        $display("%s: %0d items, %0d errors", test_name, items - item_start, errors - err_start);
    endtask

    // fetch side, compares every record and acks after 0..5 cycles
    initial begin : fetch_side
        redirect_t got;
        redirect_t exp;
        int        delay;
        forever begin
            @(negedge clk);
            if (!rst && redir_req) begin
                got = redir_rec;
                records++;
                assert (exp_q.size() > 0) else begin
                    $display("unexpected record for pc %h with no item outstanding", got.pc);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    assert (got == exp) else begin
                        $display("Mismatch in %s: expected %h actual %h", test_name, exp, got);
                        errors++;
                    end
                end
                fetch_state = lcg_step(fetch_state);
                delay = int'(fetch_state[31:16] % 16'd6);
                repeat (delay) @(negedge clk);
                redir_ack = 1'b1;
                while (redir_req) begin
                    @(negedge clk);
                end
                redir_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (N_ITEMS * 40 + 200));
        $display("timeout after %0d clock periods, handshake stuck", N_ITEMS * 40 + 200);
        $display("test failed");
        $finish;
    end

    initial begin : main
        rst         = 1'b1;
        issue_req   = 1'b0;
        issue_item  = '0;
        redir_ack   = 1'b0;
        stim_state  = SEED;
        fetch_state = ~SEED;
        errors      = 0;
        items       = 0;
        records     = 0;
        n_tests     = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("reset");
        @(negedge clk);
        assert (!issue_ack && !redir_req) else begin
            $display("handshake outputs not low after reset");
            errors++;
        end
        end_test();

        begin_test("latency");   // idle pipeline, fence item
        fork
            send_item(make_item(8, 32'h0, 32'h0, 32'h0000_1000, 32'h0, 32'h0,
                                1'b0, 1'b0, 32'h0));
            measure_latency();
        join
        end_test();

        begin_test("directed");
        send_item(make_item(3, 32'h0000_0010, 32'h0, 32'h0000_1000, 32'hffff_ffff,
                            32'h0000_0001, 1'b0, 1'b0, 32'h0));    // bge, signed false
        send_item(make_item(5, 32'hffff_fff0, 32'h0, 32'h0000_2000, 32'hffff_ffff,
                            32'h0000_0001, 1'b0, 1'b0, 32'h0));    // bgeu, unsigned true
        send_item(make_item(2, 32'h0000_0040, 32'h0, 32'h0000_2100, 32'hffff_fffb,
                            32'h0000_0003, 1'b1, 1'b0, 32'h0));    // predicted, taken
        send_item(make_item(0, 32'h0000_0040, 32'h0, 32'h0000_2200, 32'h0000_0005,
                            32'h0000_0006, 1'b1, 1'b0, 32'h0));    // rollback
        send_item(make_item(7, 32'h0000_0005, 32'h0, 32'h0000_2300, 32'h0000_3000,
                            32'h0, 1'b0, 1'b0, 32'h0));            // jalr bit 0 cleared
        send_item(make_item(6, 32'h0000_0102, 32'h0, 32'h0000_2400, 32'h0, 32'h0,
                            1'b0, 1'b0, 32'h0));                   // jal misaligned
        send_item(make_item(8, 32'h0, 32'h0, 32'h0000_2500, 32'h0, 32'h0,
                            1'b0, 1'b0, 32'h0));
        send_item(make_item(9, 32'h0, 32'h0, 32'h0000_2600, 32'h0, 32'h0,
                            1'b0, 1'b1, 32'h0000_0100));           // interrupt wins
        end_test();

        begin_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            send_item(random_item());
        end
        end_test();

        repeat (10) @(negedge clk);   // room for a stray duplicate
        assert (records == items && exp_q.size() == 0) else begin
            $display("record count %0d does not match item count %0d", records, items);
            errors++;
        end
        $display("tests %0d, items %0d, records %0d, errors %0d", n_tests, items, records, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
logic/bru_pkg.sv
logic/hs_slot.sv
logic/bjp_decode.sv
logic/exu_bru.sv
logic/bru_top.sv
dv/bru_properties.sv
dv/tb_bru_top.sv

//--- Makefile
# Verilator flow for the branch resolution slice

VERILATOR ?= verilator
TOP       ?= tb_bru_top
FILELIST  ?= list.f
VFLAGS    ?= --timing --assert
BUILD_DIR ?= obj_dir
PASS_MSG  := test passed

.PHONY: all lint sim clean

all: sim

# static checks only, no build
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
